/* rtl/fxp_pkg.sv */
package fxp_pkg;

    // ------------------------------
    // Q16.16 format
    // ------------------------------

    // Operand and accumulator width
    localparam int DATA_WIDTH = 32;
    // Fractional bits, binary point only names the format
    localparam int FRAC_BITS  = 16;

    // Signed fixed-point word
    typedef logic signed [DATA_WIDTH-1:0] fxp_word_t;

    // ------------------------------
    // Operation codes
    // ------------------------------

    typedef logic [1:0] fxp_op_t;

    localparam fxp_op_t OP_ADD   = 2'd0;
    localparam fxp_op_t OP_SUB   = 2'd1;
    localparam fxp_op_t OP_LOAD  = 2'd2;
    localparam fxp_op_t OP_CLEAR = 2'd3;

    // Saturation limits, two's complement extremes
    localparam fxp_word_t FXP_MAX = 32'h7fff_ffff;
    localparam fxp_word_t FXP_MIN = 32'h8000_0000;

endpackage : fxp_pkg

/* rtl/carry_lookahead_add.sv */
module carry_lookahead_add #(
    // Datapath width in bits
    parameter int N = 32
) (
    // Addends
    input  logic [N-1:0] a,
    input  logic [N-1:0] b,
    // Carry into bit 0
    input  logic         ci,
    // Sum and carry out of the top bit
    output logic [N-1:0] c,
    output logic         co
);

    // Per-bit generate and propagate
    logic [N-1:0] gen;
    logic [N-1:0] prop;
    // Propagate without generate, i.e. exactly one input set
    logic [N-1:0] gen_n;
    logic [N-1:0] half;
    // Carry into each bit
    logic [N-1:0] carry;
    // Sum gate terms
    logic [N-1:0] carry_and_half;
    logic [N-1:0] carry_or_half;

    // ------------------------------
    // Bit slices
    // ------------------------------
    genvar i;
    generate
        for (i = 0; i < N; i = i + 1) begin : g_bit
            // Generate when both set, propagate when either set
            assign gen[i]   = a[i] & b[i];
            assign prop[i]  = a[i] | b[i];
            assign gen_n[i] = ~gen[i];
            assign half[i]  = gen_n[i] & prop[i];

            // Carry chain seeded from carry in
            if (i == 0) begin : g_first
                assign carry[i] = ci;
            end else begin : g_chain
                // Carry out of previous bit
                assign carry[i] = gen[i-1] | (prop[i-1] & carry[i-1]);
            end

            // Sum bit is half XOR carry, built from and/or/not
            assign carry_and_half[i] = carry[i] & half[i];
            assign carry_or_half[i]  = carry[i] | half[i];
            assign c[i]              = ~carry_and_half[i] & carry_or_half[i];
        end : g_bit
    endgenerate

    // Carry out of the top bit
    assign co = gen[N-1] | (prop[N-1] & carry[N-1]);

    // ------------------------------
    // Checks
    // ------------------------------

    // Whole chain must match an (N+1)-bit add, deferred past settling
    always_comb begin
        assert final ({co, c} == ({1'b0, a} + {1'b0, b} + {{N{1'b0}}, ci}))
        else $error("carry_lookahead_add: sum mismatch a=%h b=%h ci=%b", a, b, ci);
    end

endmodule : carry_lookahead_add

/* rtl/fxp_addsub.sv */
module fxp_addsub (
    // Accumulator side operand
    input  fxp_pkg::fxp_word_t a,
    // Incoming operand
    input  fxp_pkg::fxp_word_t b,
    // High for a minus b
    input  logic               subtract,
    // Saturated result
    output fxp_pkg::fxp_word_t result,
    // Signed overflow of the raw sum
    output logic               overflow
);

    import fxp_pkg::*;

    // Second adder input after optional complement
    fxp_word_t b_eff;
    // Adder output before saturation
    fxp_word_t raw_sum;
    logic      carry_out;
    // Carry into the sign bit
    logic      carry_msb;
    // Sign bits of the effective operands
    logic      sign_a;
    logic      sign_b;

    // ------------------------------
    // Operand conditioning
    // ------------------------------

    // a - b as a + ~b + 1
    assign b_eff = subtract ? ~b : b;

    assign sign_a = a[DATA_WIDTH-1];
    assign sign_b = b_eff[DATA_WIDTH-1];

    // ------------------------------
    // Adder
    // ------------------------------
    carry_lookahead_add #(
        .N  (DATA_WIDTH)
    ) u_add (
        .a  (a),
        .b  (b_eff),
        .ci (subtract),
        .c  (raw_sum),
        .co (carry_out)
    );

    // ------------------------------
    // Overflow and saturation
    // ------------------------------

    // Sum bit = a ^ b ^ carry in, so carry in falls out of the XOR
    assign carry_msb = sign_a ^ sign_b ^ raw_sum[DATA_WIDTH-1];

    // Carry into and out of sign bit disagree
    assign overflow = carry_out ^ carry_msb;

    // Overflow only with like signs, so sign of a is the true sign
    always_comb begin
        if (overflow) begin
            result = sign_a ? FXP_MIN : FXP_MAX;
        end else begin
            result = raw_sum;
        end
    end

    // Unlike signs can never leave the range
    always_comb begin
        assert final (!overflow || (sign_a == sign_b))
        else $error("fxp_addsub: overflow with unlike operand signs a=%h b=%h", a, b_eff);
    end

endmodule : fxp_addsub

/* rtl/fxp_accum.sv */
module fxp_accum (
    input  logic               clk,
    input  logic               reset,
    // One-cycle command strobe
    input  logic               in_valid,
    input  fxp_pkg::fxp_op_t   op,
    input  fxp_pkg::fxp_word_t operand,
    // Result from the add/subtract unit
    input  fxp_pkg::fxp_word_t sum,
    input  logic               overflow,
    // Direction for the add/subtract unit
    output logic               subtract,
    // Accumulator state
    output fxp_pkg::fxp_word_t acc,
    // Sticky since last LOAD or CLEAR
    output logic               saturated,
    // One pulse per accepted strobe
    output logic               out_valid
);

    import fxp_pkg::*;

    // Operation decode
    logic is_reload;

    // ------------------------------
    // Decode
    // ------------------------------

    // Only SUB flips the arithmetic unit
    assign subtract = (op == OP_SUB);

    // LOAD and CLEAR restart the flag
    assign is_reload = (op == OP_LOAD) || (op == OP_CLEAR);

    // ------------------------------
    // Accumulator register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            saturated <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            // Result pulse one cycle after each strobe
            out_valid <= in_valid;

            if (in_valid) begin
                case (op)
                    OP_ADD, OP_SUB: begin
                        // Sum already clamped upstream
                        acc <= sum;
                        if (overflow) begin
                            saturated <= 1'b1;
                        end
                    end
                    OP_LOAD: begin
                        acc       <= operand;
                        saturated <= 1'b0;
                    end
                    default: begin
                        // CLEAR
                        acc       <= '0;
                        saturated <= 1'b0;
                    end
                endcase
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // Pulse tracks the strobe with exactly one cycle of latency
    assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(in_valid && !reset))
    else $error("fxp_accum: out_valid does not follow in_valid");

    // Flag drops only through reset or a reload command
    assert property (@(posedge clk) disable iff (reset)
        $fell(saturated) |-> ($past(reset) || $past(in_valid && is_reload)))
    else $error("fxp_accum: saturated cleared without LOAD or CLEAR");

endmodule : fxp_accum

/* rtl/fxp_accum_top.sv */
module fxp_accum_top (
    input  logic               clk,
    input  logic               reset,
    // Command strobe and payload
    input  logic               in_valid,
    input  fxp_pkg::fxp_op_t   op,
    input  fxp_pkg::fxp_word_t operand,
    // Accumulator and status
    output fxp_pkg::fxp_word_t acc,
    output logic               saturated,
    output logic               out_valid
);

    import fxp_pkg::*;

    // Between accumulator and arithmetic unit
    logic      subtract;
    fxp_word_t sum;
    logic      overflow;

    // ------------------------------
    // Accumulator and control
    // ------------------------------
    fxp_accum u_accum (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .op        (op),
        .operand   (operand),
        .sum       (sum),
        .overflow  (overflow),
        .subtract  (subtract),
        .acc       (acc),
        .saturated (saturated),
        .out_valid (out_valid)
    );

    // Combinational add/subtract with clamp
    fxp_addsub u_addsub (
        .a        (acc),
        .b        (operand),
        .subtract (subtract),
        .result   (sum),
        .overflow (overflow)
    );

endmodule : fxp_accum_top

/* bench/fxp_accum_tb.sv */
module fxp_accum_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import fxp_pkg::*;

    // DUT signals
    logic      clk;
    logic      reset;
    logic      in_valid;
    fxp_op_t   op;
    fxp_word_t operand;
    fxp_word_t acc;
    logic      saturated;
    logic      out_valid;

    // Reference model state, one result per accepted strobe
    fxp_word_t   exp_acc;
    logic        exp_sat;
    logic [32:0] model_out;

    // Bookkeeping
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          test_errors_at_start;
    string       test_name;
    int          strobe_count;
    int          pulse_count;
    logic [31:0] rng;

    fxp_accum_top uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .op        (op),
        .operand   (operand),
        .acc       (acc),
        .saturated (saturated),
        .out_valid (out_valid)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ------------------------------
    // Reference model
    // ------------------------------

    // Returns {flag, acc} after one operation, saturating on range
    function automatic logic [32:0] model_next(input fxp_op_t op_i, input fxp_word_t acc_i,
                                               input fxp_word_t val, input logic sat_i);
        longint wide;
        wide = 0;
        case (op_i)
            OP_ADD:  wide = longint'(acc_i) + longint'(val);
            OP_SUB:  wide = longint'(acc_i) - longint'(val);
            OP_LOAD: return {1'b0, val};
            default: return {1'b0, 32'h0000_0000};
        endcase
        if (wide > longint'(FXP_MAX)) begin
            return {1'b1, FXP_MAX};
        end
        if (wide < longint'(FXP_MIN)) begin
            return {1'b1, FXP_MIN};
        end
        return {sat_i, fxp_word_t'(wide)};
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            exp_acc <= '0;
            exp_sat <= 1'b0;
        end else if (in_valid) begin
            model_out = model_next(op, exp_acc, operand, exp_sat);
            exp_acc   <= model_out[31:0];
            exp_sat   <= model_out[32];
        end
    end

    // Pulses seen at the clock, matched against strobes sent
    always @(posedge clk) begin
        if (reset) begin
            pulse_count <= 0;
        end else if (out_valid) begin
            pulse_count <= pulse_count + 1;
        end
    end

    // ------------------------------
    // Checking assertions
    // ------------------------------
    acc_matches_model: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (acc == exp_acc))
    else begin
        errors++;
        $display("** Error acc: expected %h, actual %h", $sampled(exp_acc), $sampled(acc));
    end

    flag_matches_model: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (saturated == exp_sat))
    else begin
        errors++;
        $display("** Error saturated: expected %h, actual %h",
                 $sampled(exp_sat), $sampled(saturated));
    end

    // One pulse, exactly one cycle after each strobe
    pulse_follows_strobe: assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(in_valid))
    else begin
        errors++;
        $display("** Error out_valid: expected %h, actual %h",
                 !$sampled(out_valid), $sampled(out_valid));
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Q16.16 as a real, for readable error lines
    function automatic real to_real(input fxp_word_t v);
        return $itor(v) / $itor(1 << FRAC_BITS);
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic send(input fxp_op_t op_i, input fxp_word_t val);
        in_valid = 1'b1;
        op       = op_i;
        operand  = val;
        strobe_count++;
        tick();
        in_valid = 1'b0;
    endtask

    task automatic finish_run();
        $display("Summary: %0d tests ok, %0d tests failed, %0d check errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // Every strobe sent so far must come back as a pulse
    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (pulse_count != strobe_count && cycles < 20) begin
            tick();
            cycles++;
        end
        if (pulse_count != strobe_count) begin
            $display("Timeout: %0d result pulses still missing after 20 cycles",
                     strobe_count - pulse_count);
            errors++;
            finish_run();
        end
    endtask

    task automatic check_state(input fxp_word_t want_acc, input logic want_sat);
        assert (acc == want_acc)
        else begin
            errors++;
            $display("** Error acc: expected %h, actual %h (%f)", want_acc, acc, to_real(acc));
        end
        assert (saturated == want_sat)
        else begin
            errors++;
            $display("** Error saturated: expected %h, actual %h", want_sat, saturated);
        end
    endtask

    task automatic start_test(input string name);
        test_name            = name;
        test_errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors_at_start) begin
            tests_ok++;
            $display("Test %-24s ok", test_name);
        end else begin
            tests_bad++;
            $display("Test %-24s FAILED, %0d errors", test_name, errors - test_errors_at_start);
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        op           = OP_ADD;
        operand      = '0;
        errors       = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        strobe_count = 0;
        rng          = 32'h9e99c454;

        repeat (10) tick();
        reset = 1'b0;
        tick();

        start_test("reset state");
        check_state(32'h0000_0000, 1'b0);
        assert (out_valid == 1'b0)
        else begin
            errors++;
            $display("** Error out_valid: expected %h, actual %h", 1'b0, out_valid);
        end
        end_test();

        // 1.5 + 2.25 - 0.5
        start_test("small add and sub");
        send(OP_LOAD, 32'h0001_8000);
        wait_result();
        send(OP_ADD, 32'h0002_4000);
        wait_result();
        check_state(32'h0003_c000, 1'b0);
        send(OP_SUB, 32'h0000_8000);
        wait_result();
        check_state(32'h0003_4000, 1'b0);
        end_test();

        start_test("saturate high");
        send(OP_LOAD, 32'h4000_0000);
        send(OP_ADD, 32'h6000_0000);
        send(OP_ADD, 32'h6000_0000);
        wait_result();
        check_state(32'h7fff_ffff, 1'b1);
        // Flag is sticky across an in-range result
        send(OP_SUB, 32'h0001_0000);
        wait_result();
        check_state(32'h7ffe_ffff, 1'b1);
        end_test();

        start_test("saturate low and clear");
        send(OP_LOAD, 32'hc000_0000);
        send(OP_SUB, 32'h6000_0000);
        wait_result();
        check_state(32'h8000_0000, 1'b1);
        send(OP_CLEAR, 32'h1234_5678);
        wait_result();
        check_state(32'h0000_0000, 1'b0);
        end_test();

        // 0 + 1 + 2 - 0.25 + 3, one strobe per cycle
        start_test("back to back");
        send(OP_CLEAR, '0);
        send(OP_ADD, 32'h0001_0000);
        send(OP_ADD, 32'h0002_0000);
        send(OP_SUB, 32'h0000_4000);
        send(OP_ADD, 32'h0003_0000);
        wait_result();
        check_state(32'h0005_c000, 1'b0);
        end_test();

        start_test("random operations");
        for (int n = 0; n < 200; n++) begin
            rng = lcg_next(rng);
            op  = rng[31:30];
            if (rng[27]) begin
                // Occasional idle cycle between strobes
                tick();
            end
            if (rng[29]) begin
                rng = lcg_next(rng);
                send(rng[31:30], rng);
            end else begin
                rng = lcg_next(rng);
                send(op, {{12{rng[31]}}, rng[31:12]});
            end
        end
        wait_result();
        tick();
        end_test();

        finish_run();
    end

endmodule : fxp_accum_tb

/* fxp_accum.f */
rtl/fxp_pkg.sv
rtl/carry_lookahead_add.sv
rtl/fxp_addsub.sv
rtl/fxp_accum.sv
rtl/fxp_accum_top.sv
bench/fxp_accum_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= fxp_accum_tb
FILELIST  ?= fxp_accum.f

BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into $(LOG), check for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
